// File: ifu_fetch_top.f
+incdir+verilog
verilog/ifu_pkg.sv
verilog/ifu_imem_ctrl.sv
verilog/ifu_align_queue.sv
verilog/ifu_fetch_top.sv
tests/ifu_fetch_top_props.sv
tests/ifu_fetch_top_tb.sv

// File: Makefile
TOP := ifu_fetch_top_tb

sim:
	verilator --binary --timing --assert -Wno-fatal --top-module $(TOP) \
		-f ifu_fetch_top.f -Mdir obj_dir -o $(TOP)
	./obj_dir/$(TOP) +verilator+error+limit+1000 | tee sim.log
	grep -q "Simulation completed successfully" sim.log

clean:
	rm -rf obj_dir sim.log

.PHONY: sim clean

// File: tests/ifu_fetch_top_tb.sv
// Memory answers in order within 1 to 3 cycles; error window 0x4000-0x4007; run limit 4000 cycles
`timescale 1ns/100ps
`include "ifu_macros.svh"

module ifu_fetch_top_tb;

    localparam logic [31:0] ERR_LO    = 32'h0000_4000;
    localparam logic [31:0] ERR_END   = 32'h0000_4008;  // Two faulting words
    localparam int          N_TESTS   = 7;
    localparam int          TEST_CYC  = 400;
    localparam int          MAX_CYC   = (N_TESTS + 3) * TEST_CYC;

    typedef struct packed {
        logic [31:0] addr;
        logic [31:0] due;   // Cycle of the response
    } mem_req_t;

    logic                 clk;
    logic                 rst_n;
    ifu_pkg::fetch_ctrl_t ctrl_i;
    logic                 imem_req_o;
    logic [`IFU_XLEN-1:0] imem_addr_o;
    logic                 imem_ack_i;
    ifu_pkg::imem_resp_e  imem_resp_i;
    logic [`IFU_XLEN-1:0] imem_rdata_i;
    ifu_pkg::idu_out_t    idu_o;
    logic                 idu_rdy_i;

    mem_req_t             rq[$];        // Accepted, not yet answered
    logic [31:0]          last_due;
    int unsigned          pend_cnt;
    int unsigned          cyc;
    bit                   rdy_mode;     // 1: random long stalls
    bit                   rdy_level;
    int unsigned          rdy_left;

    logic [31:0]          walk_pc;      // Scoreboard walk
    bit                   walk_on;
    bit                   err_seen;
    bit                   stopped;
    bit                   drained;      // In-flight words after a stop all gone
    int unsigned          n_consumed;
    int unsigned          n_fail;
    int unsigned          test_no;
    int unsigned          fail_base;
    int unsigned          instr_base;
    string                test_name;

    ifu_fetch_top u_ifu_fetch_top (
        .clk          (clk),
        .rst_n        (rst_n),
        .ctrl_i       (ctrl_i),
        .imem_req_o   (imem_req_o),
        .imem_addr_o  (imem_addr_o),
        .imem_ack_i   (imem_ack_i),
        .imem_resp_i  (imem_resp_i),
        .imem_rdata_i (imem_rdata_i),
        .idu_o        (idu_o),
        .idu_rdy_i    (idu_rdy_i)
    );

    always #4 clk = ~clk;

    // --------------------
    // Memory content

    function automatic logic [15:0] hw_at(input logic [31:0] a);
        logic [31:0] h;
        logic        rvi;
        h   = (a ^ (a >> 11)) * 32'h9e37_79b1;
        h   = h ^ (h >> 15);
        rvi = h[20] | (a == ERR_LO - 32'd2);  // Forced straddling RVI before the window
        return {h[31:18], rvi ? 2'b11 : {h[17], 1'b0}};
    endfunction

    function automatic bit in_err_window(input logic [31:0] a);
        logic [31:0] w;
        w = {a[31:2], 2'b00};
        return (w >= ERR_LO) && (w < ERR_END);
    endfunction

    function automatic int unsigned total_errors();
        return n_fail + u_ifu_fetch_top.u_props.err_cnt;
    endfunction

    task automatic report_value(input string sig, input logic [31:0] exp, input logic [31:0] got);
        $display("[FAIL] %s: expected 0x%h, got 0x%h (pc 0x%h)", sig, exp, got, walk_pc);
        n_fail++;
    endtask

    task automatic report_event(input string msg);
        $display("ERROR: %s in cycle %0d", msg, cyc);
        n_fail++;
    endtask

    // --------------------
    // Scoreboard

    task automatic check_instr();
        logic [15:0] lo;
        logic [15:0] hi;
        logic        rvi;
        logic [31:0] exp_instr;
        logic        exp_err;
        logic        exp_hi;
        lo        = hw_at(walk_pc);
        hi        = hw_at(walk_pc + 32'd2);
        rvi       = (lo[1:0] == 2'b11);
        exp_instr = rvi ? {hi, lo} : {16'h0000, lo};            // RVC zero extended
        exp_err   = in_err_window(walk_pc) | (rvi & in_err_window(walk_pc + 32'd2));
        exp_hi    = ~in_err_window(walk_pc) & rvi & in_err_window(walk_pc + 32'd2);
        assert (idu_o.imem_err == exp_err)
            else report_value("idu_o.imem_err", 32'(exp_err), 32'(idu_o.imem_err));
        assert (idu_o.err_rvi_hi == exp_hi)
            else report_value("idu_o.err_rvi_hi", 32'(exp_hi), 32'(idu_o.err_rvi_hi));
        if (!exp_err) begin
            assert (idu_o.instr == exp_instr)
                else report_value("idu_o.instr", exp_instr, idu_o.instr);
        end else begin
            err_seen = 1'b1;  // Stream ends here
            walk_on  = 1'b0;
        end
        walk_pc = walk_pc + (rvi ? 32'd4 : 32'd2);
        n_consumed++;
    endtask

    // Outputs sampled mid-cycle
    always @(negedge clk) begin
        mem_req_t r;
        if (rst_n) begin
            if (idu_o.vd && idu_rdy_i && walk_on) begin
                check_instr();
            end
            if (stopped) begin
                assert (!imem_req_o) else report_event("request after stop before a redirect");
                if (drained) begin
                    assert (!idu_o.vd) else report_event("valid instruction after stop drain");
                end else if ((rq.size() == 0) && (imem_resp_i == ifu_pkg::IDLE)
                             && !idu_o.vd) begin
                    drained = 1'b1;  // Nothing left in flight or queued
                end
            end
            if (err_seen) begin
                assert (!imem_req_o) else report_event("request after fetch error");
            end
            if (ctrl_i.pc_new_req) begin
                walk_pc  = ctrl_i.pc_new;
                walk_on  = 1'b1;
                err_seen = 1'b0;
                stopped  = 1'b0;
                drained  = 1'b0;
            end else if (ctrl_i.stop_fetch) begin
                walk_on = 1'b0;
                stopped = 1'b1;
                drained = 1'b0;
            end
            if (imem_req_o && imem_ack_i) begin
                r.addr = imem_addr_o;
                r.due  = cyc + 32'd1 + ($urandom % 3);
                if (r.due <= last_due) begin
                    r.due = last_due + 32'd1;  // In order, one per cycle
                end
                last_due = r.due;
                rq.push_back(r);
            end
            pend_cnt = rq.size();
        end
    end

    // --------------------
    // Memory and decoder drive

    always @(posedge clk) begin
        mem_req_t r;
        imem_ack_i <= (($urandom % 4) != 0);
        if ((rq.size() > 0) && (rq[0].due <= cyc + 32'd1)) begin
            r = rq.pop_front();
            imem_resp_i  <= in_err_window(r.addr) ? ifu_pkg::RDY_ER : ifu_pkg::RDY_OK;
            imem_rdata_i <= {hw_at(r.addr + 32'd2), hw_at(r.addr)};
        end else begin
            imem_resp_i  <= ifu_pkg::IDLE;
            imem_rdata_i <= '0;
        end
        if (!rdy_mode) begin
            idu_rdy_i <= 1'b1;
        end else begin
            if (rdy_left == 0) begin
                rdy_level = ($urandom % 2) != 0;
                rdy_left  = 4 + ($urandom % 28);  // Long stretches
            end else begin
                rdy_left--;
            end
            idu_rdy_i <= rdy_level;
        end
    end

    always @(posedge clk) begin
        if (cyc >= MAX_CYC) begin
            $display("Timeout: run exceeded %0d cycles", MAX_CYC);
            $display("Simulation failed");
            $finish;
        end else begin
            cyc <= cyc + 1;
        end
    end

    // --------------------
    // Stimulus helpers

    task automatic redirect_to(input logic [31:0] pc);
        ifu_pkg::fetch_ctrl_t c;
        c            = '0;
        c.pc_new_req = 1'b1;
        c.pc_new     = pc;
        ctrl_i <= c;
        @(posedge clk);
        ctrl_i <= '0;
    endtask

    task automatic stop_stream();
        ifu_pkg::fetch_ctrl_t c;
        c            = '0;
        c.stop_fetch = 1'b1;
        ctrl_i <= c;
        @(posedge clk);
        ctrl_i <= '0;
    endtask

    task automatic wait_instrs(input int unsigned n);
        int unsigned target;
        target = n_consumed + n;
        while (n_consumed < target) @(posedge clk);
    endtask

    task automatic start_test(input string name);
        test_no++;
        test_name  = name;
        fail_base  = total_errors();
        instr_base = n_consumed;
    endtask

    task automatic end_test();
        int unsigned errs;
        errs = total_errors() - fail_base;
        $display("test %0d %s: %s, %0d instructions, %0d errors", test_no, test_name,
                 (errs == 0) ? "ok" : "FAILED", n_consumed - instr_base, errs);
    endtask

    initial begin
        clk          = 1'b0;
        rst_n        = 1'b0;
        ctrl_i       = '0;
        imem_ack_i   = 1'b0;
        imem_resp_i  = ifu_pkg::IDLE;
        imem_rdata_i = '0;
        idu_rdy_i    = 1'b0;
        last_due     = '0;
        walk_pc      = '0;
        void'($urandom(32'hcb0d2476));
        repeat (2) @(posedge clk);
        rst_n <= 1'b1;
        @(posedge clk);

        start_test("aligned redirect");
        redirect_to(32'h0000_0100);
        wait_instrs(80);
        end_test();

        start_test("unaligned redirect");
        redirect_to(32'h0000_0802);  // Starts at upper halfword
        wait_instrs(60);
        end_test();

        start_test("redirect with responses pending");
        redirect_to(32'h0000_1000);
        while (pend_cnt < 2) @(posedge clk);
        redirect_to(32'h0000_2002);
        wait_instrs(60);
        end_test();

        start_test("fault in upper half of RVI");
        redirect_to(ERR_LO - 32'd2);
        while (!err_seen) @(posedge clk);
        repeat (16) @(posedge clk);  // No request may follow
        end_test();

        start_test("fetch into error window");
        redirect_to(ERR_LO - 32'd40);
        while (!err_seen) @(posedge clk);
        repeat (16) @(posedge clk);
        end_test();

        start_test("decoder back-pressure");
        rdy_mode <= 1'b1;
        redirect_to(32'h0000_3000);
        wait_instrs(120);
        rdy_mode <= 1'b0;
        end_test();

        start_test("stop fetch");
        redirect_to(32'h0000_0600);
        wait_instrs(12);
        stop_stream();
        repeat (24) @(posedge clk);  // Watch for requests and valid
        assert (drained) else report_event("decoder output still valid long after stop");
        end_test();

        $display("tests %0d, checked instructions %0d, errors %0d",
                 test_no, n_consumed, total_errors());
        if (total_errors() == 0) begin
            $display("Simulation completed successfully");
        end else begin
            $display("Simulation failed");
        end
        $finish;
    end

endmodule

// File: tests/ifu_fetch_top_props.sv
// Port checks only; a pending request may drop in a cycle with a redirect, a stop or a response
`timescale 1ns/100ps
`include "ifu_macros.svh"

module ifu_fetch_top_props (
    input logic                 clk,
    input logic                 rst_n,
    input ifu_pkg::fetch_ctrl_t ctrl_i,
    input logic                 imem_req_o,
    input logic [`IFU_XLEN-1:0] imem_addr_o,
    input logic                 imem_ack_i,
    input ifu_pkg::imem_resp_e  imem_resp_i,
    input ifu_pkg::idu_out_t    idu_o,
    input logic                 idu_rdy_i
);

    int unsigned err_cnt;  // Failed assertions so far
    logic        flush;
    logic        resp_any;

    assign flush    = ctrl_i.pc_new_req | ctrl_i.stop_fetch;  // Queue cleared at next edge
    assign resp_any = (imem_resp_i != ifu_pkg::IDLE);

    // --------------------
    // Memory request

    req_word_aligned: assert property (@(posedge clk) disable iff (!rst_n)
        imem_req_o |-> (imem_addr_o[1:0] == 2'b00))
        else begin err_cnt++; $error("request address not word aligned"); end

    stop_blocks_req: assert property (@(posedge clk) disable iff (!rst_n)
        ctrl_i.stop_fetch |=> !imem_req_o)
        else begin err_cnt++; $error("request in the cycle after a stop"); end

    // Held until ack unless the stream changes
    req_held: assert property (@(posedge clk) disable iff (!rst_n)
        imem_req_o && !imem_ack_i |=> imem_req_o || flush || resp_any)
        else begin err_cnt++; $error("request dropped before ack"); end

    addr_held: assert property (@(posedge clk) disable iff (!rst_n)
        imem_req_o && !imem_ack_i |=> $stable(imem_addr_o))
        else begin err_cnt++; $error("request address changed before ack"); end

    // --------------------
    // Decoder output

    rvi_hi_err_is_err: assert property (@(posedge clk) disable iff (!rst_n)
        idu_o.err_rvi_hi |-> idu_o.imem_err)
        else begin err_cnt++; $error("upper-half fault flag without fetch error"); end

    instr_held: assert property (@(posedge clk) disable iff (!rst_n)
        idu_o.vd && !idu_rdy_i && !flush |=> idu_o.vd && $stable(idu_o.instr))
        else begin err_cnt++; $error("instruction changed while decoder stalled"); end

endmodule

bind ifu_fetch_top ifu_fetch_top_props u_props (
    .clk         (clk),
    .rst_n       (rst_n),
    .ctrl_i      (ctrl_i),
    .imem_req_o  (imem_req_o),
    .imem_addr_o (imem_addr_o),
    .imem_ack_i  (imem_ack_i),
    .imem_resp_i (imem_resp_i),
    .idu_o       (idu_o),
    .idu_rdy_i   (idu_rdy_i)
);

// File: verilog/ifu_fetch_top.sv
// Fetch unit top with single-word reads, no bypass and in-order memory responses only
`timescale 1ns/100ps
`include "ifu_macros.svh"

module ifu_fetch_top (
    input  logic                 clk,
    input  logic                 rst_n,

    // Pipeline control
    input  ifu_pkg::fetch_ctrl_t ctrl_i,       // Redirect and stop

    // Memory request
    output logic                 imem_req_o,
    output logic [`IFU_XLEN-1:0] imem_addr_o,  // Word aligned
    input  logic                 imem_ack_i,

    // Memory response
    input  ifu_pkg::imem_resp_e  imem_resp_i,
    input  logic [`IFU_XLEN-1:0] imem_rdata_i,

    // Decoder side
    output ifu_pkg::idu_out_t    idu_o,
    input  logic                 idu_rdy_i
);

    // --------------------
    // Internal wires

    ifu_pkg::imem_rsp_t          rsp;          // Live responses to the queue
    logic [`IFU_Q_FREE_W_W-1:0]  q_free_w;     // Free words back to the controller

    // --------------------
    // Memory side

    ifu_imem_ctrl u_imem_ctrl (
        .clk          (clk),
        .rst_n        (rst_n),
        .ctrl_i       (ctrl_i),
        .imem_ack_i   (imem_ack_i),
        .imem_resp_i  (imem_resp_i),
        .imem_rdata_i (imem_rdata_i),
        .q_free_w_i   (q_free_w),
        .imem_req_o   (imem_req_o),
        .imem_addr_o  (imem_addr_o),
        .rsp_o        (rsp)
    );

    // --------------------
    // Decoder side

    ifu_align_queue u_align_queue (
        .clk          (clk),
        .rst_n        (rst_n),
        .ctrl_i       (ctrl_i),
        .rsp_i        (rsp),
        .idu_rdy_i    (idu_rdy_i),
        .q_free_w_o   (q_free_w),
        .idu_o        (idu_o)
    );

endmodule

// File: verilog/ifu_align_queue.sv
// Queue holds 16 halfwords and an RVI head waits for both halves; no decoder bypass
`timescale 1ns/100ps
`include "ifu_macros.svh"

module ifu_align_queue (
    input  logic                       clk,
    input  logic                       rst_n,
    input  ifu_pkg::fetch_ctrl_t       ctrl_i,
    input  ifu_pkg::imem_rsp_t         rsp_i,
    input  logic                       idu_rdy_i,
    output logic [`IFU_Q_FREE_W_W-1:0] q_free_w_o,  // After this cycle's read
    output ifu_pkg::idu_out_t          idu_o
);

    localparam int HW = `IFU_XLEN / 2;  // Halfword width

    typedef enum logic [1:0] {
        WR_NONE,
        WR_FULL,  // Both halves
        WR_HI     // Upper half only
    } q_wr_e;

    logic                       new_pc_unaligned_ff;
    logic                       new_pc_unaligned_upd;
    logic                       instr_hi_rvi_lo_ff;  // Previous word ended in RVI low half
    logic                       instr_hi_rvi_lo_next;
    logic                       instr_hi_is_rvi;
    logic                       instr_lo_is_rvi;
    logic                       resp_ok;
    ifu_pkg::instr_type_e       instr_type;

    q_wr_e                      q_wr_size;
    logic                       q_wr_en;
    logic                       q_flush;
    logic                       q_rd_vd;
    logic                       q_rd_hword;

    logic [`IFU_Q_PTR_W-1:0]    q_wptr;
    logic [`IFU_Q_PTR_W-1:0]    q_wptr_next;
    logic [`IFU_Q_PTR_W-1:0]    q_rptr;
    logic [`IFU_Q_PTR_W-1:0]    q_rptr_next;
    logic [`IFU_Q_ADR_W-1:0]    q_wr_idx;
    logic [`IFU_Q_ADR_W-1:0]    q_wr_idx_nx;
    logic [`IFU_Q_ADR_W-1:0]    q_rd_idx;
    logic [`IFU_Q_ADR_W-1:0]    q_rd_idx_nx;

    logic [HW-1:0]              q_data [`IFU_Q_SIZE_HALF];
    logic                       q_err  [`IFU_Q_SIZE_HALF];
    logic [HW-1:0]              q_data_head;
    logic [HW-1:0]              q_data_next;
    logic                       q_err_head;
    logic                       q_err_next;

    logic                       q_is_empty;
    logic                       q_has_1_ocpd_hw;
    logic                       q_head_is_rvi;
    logic [`IFU_Q_PTR_W-1:0]    q_ocpd_h;
    logic [`IFU_Q_PTR_W-1:0]    q_free_h_next;

    // --------------------
    // Alignment flags

    assign new_pc_unaligned_upd = ctrl_i.pc_new_req | rsp_i.valid;

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            new_pc_unaligned_ff <= 1'b0;
        end else if (new_pc_unaligned_upd) begin
            new_pc_unaligned_ff <= ctrl_i.pc_new_req & ctrl_i.pc_new[1]; // First word only
        end
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            instr_hi_rvi_lo_ff <= 1'b0;
        end else if (ctrl_i.pc_new_req) begin
            instr_hi_rvi_lo_ff <= 1'b0;
        end else if (rsp_i.valid) begin
            instr_hi_rvi_lo_ff <= instr_hi_rvi_lo_next;
        end
    end

    // --------------------
    // Word type decoder

    assign resp_ok         = rsp_i.valid & ~rsp_i.err;
    assign instr_hi_is_rvi = &rsp_i.rdata[HW+1:HW];
    assign instr_lo_is_rvi = &rsp_i.rdata[1:0];

    always_comb begin
        instr_type = ifu_pkg::NONE;
        if (resp_ok) begin
            if (new_pc_unaligned_ff) begin
                instr_type = instr_hi_is_rvi ? ifu_pkg::RVI_LO_NV : ifu_pkg::RVC_NV;
            end else if (instr_hi_rvi_lo_ff) begin
                instr_type = instr_hi_is_rvi ? ifu_pkg::RVI_LO_RVI_HI : ifu_pkg::RVC_RVI_HI;
            end else if (instr_lo_is_rvi) begin
                instr_type = ifu_pkg::RVI_HI_RVI_LO;
            end else begin
                instr_type = instr_hi_is_rvi ? ifu_pkg::RVI_LO_RVC : ifu_pkg::RVC_RVC;
            end
        end
    end

    assign instr_hi_rvi_lo_next = (instr_type == ifu_pkg::RVI_LO_NV)
                                | (instr_type == ifu_pkg::RVI_LO_RVI_HI)
                                | (instr_type == ifu_pkg::RVI_LO_RVC);

    // Faulted word is stored too so the error reaches the decoder
    always_comb begin
        q_wr_size = WR_NONE;
        if (rsp_i.valid) begin
            q_wr_size = new_pc_unaligned_ff ? WR_HI : WR_FULL; // Skip lower half when unaligned
        end
    end

    // --------------------
    // Pointers

    assign q_flush    = ctrl_i.pc_new_req | ctrl_i.stop_fetch;
    assign q_wr_en    = (q_wr_size != WR_NONE) & ~q_flush;
    assign q_rd_vd    = idu_o.vd & idu_rdy_i;
    assign q_rd_hword = ~q_head_is_rvi | q_err_head;  // Faulted head goes out alone

    assign q_wptr_next = q_flush ? '0
                       : q_wr_en ? q_wptr + ((q_wr_size == WR_HI) ? `IFU_Q_PTR_W'(1)
                                                                  : `IFU_Q_PTR_W'(2))
                                 : q_wptr;
    assign q_rptr_next = q_flush ? '0
                       : q_rd_vd ? q_rptr + (q_rd_hword ? `IFU_Q_PTR_W'(1) : `IFU_Q_PTR_W'(2))
                                 : q_rptr;

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            q_wptr <= '0;
            q_rptr <= '0;
        end else begin
            q_wptr <= q_wptr_next;
            q_rptr <= q_rptr_next;
        end
    end

    assign q_wr_idx    = q_wptr[`IFU_Q_ADR_W-1:0];
    assign q_wr_idx_nx = q_wr_idx + 1'b1;
    assign q_rd_idx    = q_rptr[`IFU_Q_ADR_W-1:0];
    assign q_rd_idx_nx = q_rd_idx + 1'b1;

    // --------------------
    // Halfword slots

    always_ff @(posedge clk) begin
        if (q_wr_en) begin
            if (q_wr_size == WR_HI) begin
                q_data[q_wr_idx]    <= rsp_i.rdata[`IFU_XLEN-1:HW];
                q_err[q_wr_idx]     <= rsp_i.err;
            end else begin
                q_data[q_wr_idx]    <= rsp_i.rdata[HW-1:0];
                q_err[q_wr_idx]     <= rsp_i.err;
                q_data[q_wr_idx_nx] <= rsp_i.rdata[`IFU_XLEN-1:HW];
                q_err[q_wr_idx_nx]  <= rsp_i.err;
            end
        end
    end

    assign q_data_head = q_data[q_rd_idx];
    assign q_data_next = q_data[q_rd_idx_nx];
    assign q_err_head  = q_err[q_rd_idx];
    assign q_err_next  = q_err[q_rd_idx_nx];

    // Status
    assign q_is_empty      = (q_rptr == q_wptr);
    assign q_ocpd_h        = q_wptr - q_rptr;
    assign q_has_1_ocpd_hw = (q_ocpd_h == `IFU_Q_PTR_W'(1));
    assign q_head_is_rvi   = &q_data_head[1:0];

    // Flush empties the queue at the edge
    assign q_free_h_next = q_flush ? `IFU_Q_PTR_W'(`IFU_Q_SIZE_HALF)
                                   : `IFU_Q_PTR_W'(`IFU_Q_SIZE_HALF) - (q_wptr - q_rptr_next);
    assign q_free_w_o    = q_free_h_next[`IFU_Q_PTR_W-1:1];   // Whole words only

    // --------------------
    // Decoder output

    always_comb begin
        idu_o = '0;
        if (!q_is_empty) begin
            if (q_has_1_ocpd_hw) begin
                idu_o.vd       = ~q_head_is_rvi | q_err_head;  // RVI waits for upper half
                idu_o.imem_err = q_err_head;
            end else begin
                idu_o.vd         = 1'b1;
                idu_o.imem_err   = q_err_head | (q_head_is_rvi & q_err_next);
                idu_o.err_rvi_hi = ~q_err_head & q_head_is_rvi & q_err_next;
            end
        end
        idu_o.instr = q_head_is_rvi ? {q_data_next, q_data_head}
                                    : {{HW{1'b0}}, q_data_head};  // RVC zero extended
    end

endmodule

// File: verilog/ifu_imem_ctrl.sv
// One-word reads only with in-order responses and at most 15 transactions in flight
`timescale 1ns/100ps
`include "ifu_macros.svh"

module ifu_imem_ctrl (
    input  logic                       clk,
    input  logic                       rst_n,
    input  ifu_pkg::fetch_ctrl_t       ctrl_i,
    input  logic                       imem_ack_i,
    input  ifu_pkg::imem_resp_e        imem_resp_i,
    input  logic [`IFU_XLEN-1:0]       imem_rdata_i,
    input  logic [`IFU_Q_FREE_W_W-1:0] q_free_w_i,   // Free words after this cycle's read
    output logic                       imem_req_o,
    output logic [`IFU_XLEN-1:0]       imem_addr_o,
    output ifu_pkg::imem_rsp_t         rsp_o         // Live stream only
);

    typedef enum logic {
        ST_IDLE,
        ST_FETCH
    } fsm_e;

    fsm_e                      fsm_ff;
    fsm_e                      fsm_next;
    logic                      fsm_fetch;
    logic                      fetch_req;
    logic                      stop_req;

    logic                      resp_ok;
    logic                      resp_er;
    logic                      resp_received;
    logic                      resp_er_live;   // Error on the current stream
    logic                      handshake;

    logic [`IFU_XLEN-1:2]      addr_ff;        // Word address
    logic                      addr_upd;

    logic [`IFU_TXN_CNT_W-1:0] pnd_cnt;
    logic [`IFU_TXN_CNT_W-1:0] pnd_cnt_next;
    logic                      pnd_cnt_upd;
    logic                      pnd_full;
    logic [`IFU_TXN_CNT_W-1:0] vd_pnd_cnt;     // Pending and still wanted

    logic [`IFU_TXN_CNT_W-1:0] dsc_cnt;
    logic [`IFU_TXN_CNT_W-1:0] dsc_cnt_next;
    logic                      dsc_cnt_upd;
    logic                      dsc_req;

    // --------------------
    // Response decode

    assign resp_ok       = (imem_resp_i == ifu_pkg::RDY_OK);
    assign resp_er       = (imem_resp_i == ifu_pkg::RDY_ER);
    assign resp_received = resp_ok | resp_er;
    assign resp_er_live  = resp_er & ~dsc_req;
    assign handshake     = imem_req_o & imem_ack_i;

    // --------------------
    // Fetch FSM

    assign fetch_req = ctrl_i.pc_new_req & ~ctrl_i.stop_fetch;
    assign stop_req  = ctrl_i.stop_fetch | (resp_er_live & ~ctrl_i.pc_new_req); // Halt on fault

    always_comb begin
        unique case (fsm_ff)
            ST_IDLE:  fsm_next = fetch_req ? ST_FETCH : ST_IDLE;
            ST_FETCH: fsm_next = stop_req  ? ST_IDLE  : ST_FETCH;
        endcase
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            fsm_ff <= ST_IDLE;
        end else begin
            fsm_ff <= fsm_next;
        end
    end

    assign fsm_fetch = (fsm_ff == ST_FETCH);

    // --------------------
    // Address register

    assign addr_upd = ctrl_i.pc_new_req | handshake; // No handshake in a redirect cycle

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            addr_ff <= '0;
        end else if (addr_upd) begin
            addr_ff <= ctrl_i.pc_new_req ? ctrl_i.pc_new[`IFU_XLEN-1:2]
                                         : addr_ff + 1'b1;
        end
    end

    // --------------------
    // Transaction counters

    assign pnd_cnt_upd  = handshake ^ resp_received;         // Both at once leaves it unchanged
    assign pnd_cnt_next = handshake ? pnd_cnt + 1'b1 : pnd_cnt - 1'b1;
    assign pnd_full     = &pnd_cnt;

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            pnd_cnt <= '0;
        end else if (pnd_cnt_upd) begin
            pnd_cnt <= pnd_cnt_next;
        end
    end

    // Redirect or live fault drops everything still in flight
    assign dsc_cnt_upd  = ctrl_i.pc_new_req | resp_er | (resp_ok & dsc_req);
    assign dsc_cnt_next = (ctrl_i.pc_new_req | resp_er_live)
                        ? (pnd_cnt_upd ? pnd_cnt_next : pnd_cnt)
                        : dsc_cnt - 1'b1;
    assign dsc_req      = |dsc_cnt;
    assign vd_pnd_cnt   = pnd_cnt - dsc_cnt;

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            dsc_cnt <= '0;
        end else if (dsc_cnt_upd) begin
            dsc_cnt <= dsc_cnt_next;
        end
    end

    // --------------------
    // Bus outputs

    assign imem_req_o  = fsm_fetch & ~pnd_full
                       & (q_free_w_i > vd_pnd_cnt) // Room for every live response
                       & ~dsc_cnt_upd;
    assign imem_addr_o = {addr_ff, 2'b00};

    always_comb begin
        rsp_o.valid = resp_received & ~dsc_req;
        rsp_o.err   = resp_er;
        rsp_o.rdata = imem_rdata_i;
    end

endmodule

// File: verilog/ifu_pkg.sv
// Response codes follow the memory bus encoding and struct layouts are shared by all modules
`include "ifu_macros.svh"

package ifu_pkg;

    // Memory response codes
    typedef enum logic [1:0] {
        IDLE   = 2'b00, // No response this cycle
        RDY_OK = 2'b01,
        RDY_ER = 2'b10  // Access fault
    } imem_resp_e;

    // Content of a fetched word as <upper>_<lower> halfword
    typedef enum logic [2:0] {
        NONE          = 3'b000, // Nothing usable
        RVI_HI_RVI_LO = 3'b001, // Whole RVI in one word
        RVC_RVC       = 3'b010,
        RVI_LO_RVC    = 3'b011, // RVI starts in upper half
        RVC_RVI_HI    = 3'b100, // Lower half ends previous RVI
        RVI_LO_RVI_HI = 3'b101,
        RVC_NV        = 3'b110, // Lower half skipped after unaligned PC
        RVI_LO_NV     = 3'b111
    } instr_type_e;

    typedef struct packed {
        logic                 stop_fetch;
        logic                 pc_new_req;
        logic [`IFU_XLEN-1:0] pc_new;    // May be halfword aligned
    } fetch_ctrl_t;

    // Accepted response, stale stream already removed
    typedef struct packed {
        logic                 valid;
        logic                 err;
        logic [`IFU_XLEN-1:0] rdata;
    } imem_rsp_t;

    typedef struct packed {
        logic                 vd;
        logic                 imem_err;
        logic                 err_rvi_hi; // Only second half faulted
        logic [`IFU_XLEN-1:0] instr;
    } idu_out_t;

endpackage

// File: verilog/ifu_macros.svh
// Sizes are set by hand and must agree: Q_SIZE_HALF = 2*Q_SIZE_WORD, Q_ADR_W = log2(Q_SIZE_HALF)
`ifndef IFU_MACROS_SVH
`define IFU_MACROS_SVH

// --------------------
// Datapath

// Address and instruction width
`define IFU_XLEN        32

// --------------------
// Halfword queue

`define IFU_Q_SIZE_WORD 8
`define IFU_Q_SIZE_HALF 16
`define IFU_Q_ADR_W     4
// Extra MSB tells full from empty
`define IFU_Q_PTR_W     5
`define IFU_Q_FREE_W_W  4

// Pending and discard counters, 15 in flight at most
`define IFU_TXN_CNT_W   4

`endif
